/* project.f */
+incdir+source
source/cdc_fifo_pkg.sv
source/credit_sender.sv
source/gray_sync.sv
source/flop_ram.sv
source/cdc_fifo_push_ctrl.sv
source/cdc_fifo_pop_ctrl.sv
source/cdc_fifo_credit_top.sv
test/cdc_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the CDC FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module cdc_fifo_tb -o cdc_fifo_sim
./obj_dir/cdc_fifo_sim > sim.log
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* source/cdc_fifo_credit_top.sv */
// Top level of the credit-based CDC FIFO.
// Ready/valid push in push_clk, ready/valid pop in pop_clk; one arst_n
// resets both domains. push_credits shows credits held by the sender.

`include "cdc_fifo_defines.svh"

module cdc_fifo_credit_top (
  input  logic                 push_clk,
  input  logic                 pop_clk,
  input  logic                 arst_n,
  input  logic                 push_valid,
  input  cdc_fifo_pkg::data_t  push_data,
  output logic                 push_ready,
  output cdc_fifo_pkg::count_t push_credits,
  input  logic                 pop_ready,
  output logic                 pop_valid,
  output cdc_fifo_pkg::data_t  pop_data,
  output logic                 pop_empty,
  output cdc_fifo_pkg::count_t pop_items
);

  // Credit link
  logic                link_valid;
  cdc_fifo_pkg::data_t link_data;
  logic                link_credit;

  // RAM ports
  logic                wr_en;
  cdc_fifo_pkg::addr_t wr_addr;
  cdc_fifo_pkg::data_t wr_data;
  cdc_fifo_pkg::addr_t rd_addr;
  cdc_fifo_pkg::data_t rd_data;

  // Pointer crossings
  cdc_fifo_pkg::ptr_t  wr_ptr_gray;
  cdc_fifo_pkg::ptr_t  wr_ptr_gray_sync;
  cdc_fifo_pkg::ptr_t  rd_ptr_gray;
  cdc_fifo_pkg::ptr_t  rd_ptr_gray_sync;

  credit_sender u_sender (
    .push_clk     (push_clk),
    .arst_n       (arst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .link_credit  (link_credit),
    .link_valid   (link_valid),
    .link_data    (link_data),
    .credit_count (push_credits)
  );

  cdc_fifo_push_ctrl u_push_ctrl (
    .push_clk         (push_clk),
    .arst_n           (arst_n),
    .link_valid       (link_valid),
    .link_data        (link_data),
    .link_credit      (link_credit),
    .wr_en            (wr_en),
    .wr_addr          (wr_addr),
    .wr_data          (wr_data),
    .wr_ptr_gray      (wr_ptr_gray),
    .rd_ptr_gray_sync (rd_ptr_gray_sync),
    .push_slots       ()
  );

  // Write pointer into the pop domain
  gray_sync #(
    .NumStages (`CDC_FIFO_SYNC_STAGES)
  ) u_wr_ptr_sync (
    .dst_clk  (pop_clk),
    .arst_n   (arst_n),
    .gray_in  (wr_ptr_gray),
    .gray_out (wr_ptr_gray_sync)
  );

  // Read pointer back into the push domain
  gray_sync #(
    .NumStages (`CDC_FIFO_SYNC_STAGES)
  ) u_rd_ptr_sync (
    .dst_clk  (push_clk),
    .arst_n   (arst_n),
    .gray_in  (rd_ptr_gray),
    .gray_out (rd_ptr_gray_sync)
  );

  flop_ram u_ram (
    .wr_clk  (push_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  cdc_fifo_pop_ctrl u_pop_ctrl (
    .pop_clk          (pop_clk),
    .arst_n           (arst_n),
    .wr_ptr_gray_sync (wr_ptr_gray_sync),
    .rd_addr          (rd_addr),
    .rd_data          (rd_data),
    .rd_ptr_gray      (rd_ptr_gray),
    .pop_ready        (pop_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .pop_empty        (pop_empty),
    .pop_items        (pop_items)
  );

endmodule

/* source/cdc_fifo_defines.svh */
// Size parameters of the credit-based CDC FIFO.
// Included by the package and by any RTL file that sizes storage or
// compares against the depth.

`ifndef CDC_FIFO_DEFINES_SVH
`define CDC_FIFO_DEFINES_SVH

// Number of entries, must be a power of two
`define CDC_FIFO_DEPTH 8

// Payload width in bits
`define CDC_FIFO_WIDTH 8

// Flop stages in each pointer synchronizer, at least 2
`define CDC_FIFO_SYNC_STAGES 2

`endif

/* source/cdc_fifo_pkg.sv */
// Shared types and pointer helpers for the credit-based CDC FIFO.
// Other files refer to these with cdc_fifo_pkg:: scoped names.

package cdc_fifo_pkg;

  `include "cdc_fifo_defines.svh"

  typedef logic [`CDC_FIFO_WIDTH-1:0] data_t;
  // Extra MSB is the wrap bit
  typedef logic [$clog2(`CDC_FIFO_DEPTH):0] ptr_t;
  typedef logic [$clog2(`CDC_FIFO_DEPTH+1)-1:0] count_t;
  typedef logic [$clog2(`CDC_FIFO_DEPTH)-1:0] addr_t;

  typedef enum logic {
    CREDIT_INIT,
    CREDIT_RUN
  } credit_state_t;

  function automatic ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(ptr_t gray);
    ptr_t bin;
    bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
    for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* source/cdc_fifo_pop_ctrl.sv */
// Pop-side control of the CDC FIFO.
// Compares the synchronized write pointer against the read pointer,
// presents the head entry as ready/valid and publishes the Gray read pointer.

module cdc_fifo_pop_ctrl (
  input  logic                 pop_clk,
  input  logic                 arst_n,
  input  cdc_fifo_pkg::ptr_t   wr_ptr_gray_sync,
  output cdc_fifo_pkg::addr_t  rd_addr,
  input  cdc_fifo_pkg::data_t  rd_data,
  output cdc_fifo_pkg::ptr_t   rd_ptr_gray,
  input  logic                 pop_ready,
  output logic                 pop_valid,
  output cdc_fifo_pkg::data_t  pop_data,
  output logic                 pop_empty,
  output cdc_fifo_pkg::count_t pop_items
);

  cdc_fifo_pkg::ptr_t   wr_ptr_bin;
  cdc_fifo_pkg::ptr_t   rd_ptr;
  cdc_fifo_pkg::ptr_t   rd_ptr_next;
  cdc_fifo_pkg::ptr_t   rd_ptr_gray_q;
  cdc_fifo_pkg::count_t items;
  logic                 pop_fire;

  assign wr_ptr_bin = cdc_fifo_pkg::gray2bin(wr_ptr_gray_sync);

  // Wrap bit keeps full and empty apart
  assign items = cdc_fifo_pkg::count_t'(wr_ptr_bin - rd_ptr);

  assign pop_valid = (items != '0);
  assign pop_empty = (items == '0);
  assign pop_items = items;

  // Head entry read straight out of the RAM
  assign rd_addr  = cdc_fifo_pkg::addr_t'(rd_ptr);
  assign pop_data = rd_data;

  assign pop_fire    = pop_valid & pop_ready;
  assign rd_ptr_next = rd_ptr + cdc_fifo_pkg::ptr_t'(pop_fire);

  always_ff @(posedge pop_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr        <= '0;
      rd_ptr_gray_q <= '0;
    end else begin
      rd_ptr        <= rd_ptr_next;
      // Registered so the crossing sees a clean single-bit change
      rd_ptr_gray_q <= cdc_fifo_pkg::bin2gray(rd_ptr_next);
    end
  end

  assign rd_ptr_gray = rd_ptr_gray_q;

  // Head slot must not be overwritten while it waits to be popped
  a_pop_stable: assert property (
    @(posedge pop_clk) disable iff (!arst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data))
  ) else $error("pop_valid or pop_data changed while stalled");

endmodule

/* source/cdc_fifo_push_ctrl.sv */
// Push-side control of the CDC FIFO.
// Writes linked words into the RAM, publishes the Gray write pointer,
// and returns credits: the full depth after reset, then one per freed slot.

`include "cdc_fifo_defines.svh"

module cdc_fifo_push_ctrl (
  input  logic                 push_clk,
  input  logic                 arst_n,
  input  logic                 link_valid,
  input  cdc_fifo_pkg::data_t  link_data,
  output logic                 link_credit,
  output logic                 wr_en,
  output cdc_fifo_pkg::addr_t  wr_addr,
  output cdc_fifo_pkg::data_t  wr_data,
  output cdc_fifo_pkg::ptr_t   wr_ptr_gray,
  input  cdc_fifo_pkg::ptr_t   rd_ptr_gray_sync,
  output cdc_fifo_pkg::count_t push_slots
);

  localparam cdc_fifo_pkg::count_t Depth = cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH);

  cdc_fifo_pkg::ptr_t            wr_ptr;
  cdc_fifo_pkg::ptr_t            wr_ptr_next;
  cdc_fifo_pkg::ptr_t            wr_ptr_gray_q;
  cdc_fifo_pkg::ptr_t            rd_ptr_bin;
  cdc_fifo_pkg::ptr_t            rd_ptr_bin_q;
  cdc_fifo_pkg::count_t          freed;
  cdc_fifo_pkg::count_t          pending;
  cdc_fifo_pkg::count_t          init_cnt;
  cdc_fifo_pkg::credit_state_t   state;
  logic                          credit_return;
  logic                          link_credit_q;

  // Write goes straight through in the cycle it arrives
  assign wr_en   = link_valid;
  assign wr_addr = cdc_fifo_pkg::addr_t'(wr_ptr);
  assign wr_data = link_data;

  assign wr_ptr_next = wr_ptr + cdc_fifo_pkg::ptr_t'(link_valid);

  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr        <= '0;
      wr_ptr_gray_q <= '0;
    end else begin
      wr_ptr        <= wr_ptr_next;
      wr_ptr_gray_q <= cdc_fifo_pkg::bin2gray(wr_ptr_next);
    end
  end

  assign wr_ptr_gray = wr_ptr_gray_q;

  // Read pointer as seen from the push side
  assign rd_ptr_bin = cdc_fifo_pkg::gray2bin(rd_ptr_gray_sync);
  assign freed      = cdc_fifo_pkg::count_t'(rd_ptr_bin - rd_ptr_bin_q);
  assign push_slots = Depth - cdc_fifo_pkg::count_t'(wr_ptr - rd_ptr_bin);

  assign credit_return = (state == cdc_fifo_pkg::CREDIT_RUN) && (pending != '0);

  // Slots freed during init wait in pending until RUN
  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= cdc_fifo_pkg::CREDIT_INIT;
      init_cnt      <= '0;
      pending       <= '0;
      rd_ptr_bin_q  <= '0;
      link_credit_q <= 1'b0;
    end else begin
      rd_ptr_bin_q  <= rd_ptr_bin;
      pending       <= pending + freed - cdc_fifo_pkg::count_t'(credit_return);
      link_credit_q <= (state == cdc_fifo_pkg::CREDIT_INIT) || credit_return;
      if (state == cdc_fifo_pkg::CREDIT_INIT) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == Depth - 1'b1) begin
          state <= cdc_fifo_pkg::CREDIT_RUN;
        end
      end
    end
  end

  assign link_credit = link_credit_q;

  // Credit protocol across the sender: a word never arrives without room
  a_no_push_when_full: assert property (
    @(posedge push_clk) disable iff (!arst_n)
    link_valid |-> (push_slots != '0)
  ) else $error("word pushed with no free slot");

endmodule

/* source/credit_sender.sv */
// Credit sender on the push side of the CDC FIFO.
// Turns the user's ready/valid push into a credit/valid link and
// keeps the count of credits held for the receiver.

`include "cdc_fifo_defines.svh"

module credit_sender (
  input  logic                 push_clk,
  input  logic                 arst_n,
  input  logic                 push_valid,
  input  cdc_fifo_pkg::data_t  push_data,
  output logic                 push_ready,
  input  logic                 link_credit,
  output logic                 link_valid,
  output cdc_fifo_pkg::data_t  link_data,
  output cdc_fifo_pkg::count_t credit_count
);

  localparam cdc_fifo_pkg::count_t MaxCredit = cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH);

  cdc_fifo_pkg::count_t credit_cnt;
  cdc_fifo_pkg::count_t credit_next;

  // One credit buys one word
  assign push_ready = (credit_cnt != '0);

  // The link carries exactly the accepted handshakes
  assign link_valid = push_valid & push_ready;
  assign link_data  = push_data;

  // Returned credit and forwarded word can land in the same cycle
  always_comb begin
    credit_next = credit_cnt;
    if (link_credit) begin
      credit_next = credit_next + 1'b1;
    end
    if (link_valid) begin
      credit_next = credit_next - 1'b1;
    end
  end

  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= '0;
    end else begin
      credit_cnt <= credit_next;
    end
  end

  assign credit_count = credit_cnt;

  // Receiver must never return more credits than the FIFO has slots
  a_credit_bound: assert property (
    @(posedge push_clk) disable iff (!arst_n)
    credit_cnt <= MaxCredit
  ) else $error("credit count above FIFO depth");

  a_credit_no_overflow: assert property (
    @(posedge push_clk) disable iff (!arst_n)
    (link_credit && !link_valid) |-> (credit_cnt != MaxCredit)
  ) else $error("credit returned while sender already holds full depth");

endmodule

/* source/flop_ram.sv */
// Flop-based storage for the CDC FIFO entries.
// One write port in the push clock and an asynchronous read port
// sampled by the pop side; swap for a vendor RAM of the same shape.

`include "cdc_fifo_defines.svh"

module flop_ram (
  input  logic                wr_clk,
  input  logic                wr_en,
  input  cdc_fifo_pkg::addr_t wr_addr,
  input  cdc_fifo_pkg::data_t wr_data,
  input  cdc_fifo_pkg::addr_t rd_addr,
  output cdc_fifo_pkg::data_t rd_data
);

  cdc_fifo_pkg::data_t mem [`CDC_FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read side sees a word only after the write pointer has crossed,
  // so the entry is settled by then
  assign rd_data = mem[rd_addr];

endmodule

/* source/gray_sync.sv */
// Synchronizer for one Gray-coded FIFO pointer.
// The source must change at most one bit per source cycle, so every
// sampled value is either the old or the new pointer.

module gray_sync #(
  parameter int NumStages = 2
) (
  input  logic                dst_clk,
  input  logic                arst_n,
  input  cdc_fifo_pkg::ptr_t  gray_in,
  output cdc_fifo_pkg::ptr_t  gray_out
);

  cdc_fifo_pkg::ptr_t sync_q [NumStages];

  always_ff @(posedge dst_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NumStages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      // First stage may go metastable
      sync_q[0] <= gray_in;
      for (int i = 1; i < NumStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign gray_out = sync_q[NumStages-1];

endmodule

/* test/cdc_fifo_tb.sv */
// Testbench for the credit-based CDC FIFO.
// Reads commands from test/cdc_fifo_tests.txt, pushes words, drives pop
// back-pressure and checks order, credits and occupancy against a queue.

`include "cdc_fifo_defines.svh"

module cdc_fifo_tb;

  localparam cdc_fifo_pkg::count_t Depth = cdc_fifo_pkg::count_t'(`CDC_FIFO_DEPTH);
  localparam int PushLimit = 200;
  localparam int HoldLimit = 20;
  localparam int WaitLimit = 500;
  localparam int ModeHold = 0;
  localparam int ModeReady = 1;
  localparam int ModeRandom = 2;
  localparam logic [63:0] CmdPush = 64'("push");
  localparam logic [63:0] CmdDrain = 64'("drain");
  localparam logic [63:0] CmdHold = 64'("hold");
  localparam logic [63:0] CmdRand = 64'("rand");
  localparam logic [63:0] CmdComment = 64'("#");

  logic                 push_clk = 1'b0;
  logic                 pop_clk = 1'b0;
  logic                 pop_started = 1'b0;
  logic                 arst_n = 1'b0;
  logic                 push_valid = 1'b0;
  cdc_fifo_pkg::data_t  push_data = '0;
  logic                 push_ready;
  cdc_fifo_pkg::count_t push_credits;
  logic                 pop_ready = 1'b0;
  logic                 pop_valid;
  cdc_fifo_pkg::data_t  pop_data;
  logic                 pop_empty;
  cdc_fifo_pkg::count_t pop_items;

  cdc_fifo_pkg::data_t  expected[$];
  int                   errors = 0;
  int                   accepted_cnt = 0;
  int                   popped_cnt = 0;
  int                   hold_accepted = 0;
  int                   pop_mode = ModeReady;
  logic [31:0]          lfsr = 32'h7b758034;

  cdc_fifo_credit_top dut (
    .push_clk     (push_clk),
    .pop_clk      (pop_clk),
    .arst_n       (arst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .push_credits (push_credits),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .pop_empty    (pop_empty),
    .pop_items    (pop_items)
  );

  always #5 push_clk = ~push_clk;

  // Pop clock runs 3 units behind the push clock
  always begin
    if (!pop_started) begin
      pop_started = 1'b1;
      #3;
    end
    #5 pop_clk = ~pop_clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Fail %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // Pop side drives pop_ready and checks each transfer before its edge
  always @(negedge pop_clk) begin : pop_side
    logic [31:0] r;
    if (!arst_n) begin
      pop_ready = 1'b0;
    end else begin
      if (pop_mode == ModeRandom) begin
        random_bits(1, r);
        pop_ready = r[0];
      end else begin
        pop_ready = (pop_mode == ModeReady);
      end
      if (pop_ready && pop_valid) begin
        if (expected.size() == 0) begin
          $display("Error at %0t: the FIFO popped a word that was never pushed", $time);
          errors++;
        end else begin
          check_value(32'(pop_data), 32'(expected.pop_front()), "pop data order");
          popped_cnt++;
        end
      end
    end
  end

  // Caller sits on a falling push_clk edge; returns on one too
  task automatic push_word(input cdc_fifo_pkg::data_t value, input int limit, output logic taken);
    int waited;
    waited = 0;
    push_valid = 1'b1;
    push_data = value;
    while (!push_ready && waited < limit) begin
      @(negedge push_clk);
      waited++;
    end
    taken = push_ready;
    if (taken) begin
      expected.push_back(value);
      accepted_cnt++;
      hold_accepted++;
      @(negedge push_clk);
    end
    push_valid = 1'b0;
  endtask

  task automatic wait_credits(input string msg);
    int waited;
    waited = 0;
    while (push_credits != Depth && waited < WaitLimit) begin
      @(negedge push_clk);
      waited++;
    end
    if (push_credits != Depth) begin
      $display("Timeout at %0t: credits never came back to the depth %s", $time, msg);
      errors++;
    end
    check_value(32'(push_credits), 32'(Depth), {"credits ", msg});
  endtask

  task automatic drain_fifo();
    int waited;
    waited = 0;
    pop_mode = ModeReady;
    while ((expected.size() != 0 || !pop_empty) && waited < WaitLimit) begin
      @(negedge push_clk);
      waited++;
    end
    if (expected.size() != 0) begin
      $display("Timeout at %0t: %0d words never left the FIFO", $time, expected.size());
      errors++;
    end
    check_value(32'(pop_empty), 32'd1, "pop_empty after drain");
    wait_credits("after drain");
  endtask

  // With pops stopped the FIFO holds exactly the depth
  task automatic check_full_hold();
    int waited;
    waited = 0;
    check_value(32'(hold_accepted), 32'(Depth), "words accepted under hold");
    check_value(32'(push_credits), 32'd0, "credits when full");
    check_value(32'(push_ready), 32'd0, "push_ready when full");
    while (32'(pop_items) != 32'(accepted_cnt - popped_cnt) && waited < WaitLimit) begin
      @(negedge push_clk);
      waited++;
    end
    check_value(32'(pop_items), 32'(accepted_cnt - popped_cnt), "pop_items under hold");
  endtask

  initial begin : main_seq
    int fd;
    int status;
    logic [63:0] cmd;
    logic [31:0] arg;
    logic [31:0] rnd;
    logic taken;
    logic [1023:0] line_buf;
    repeat (10) @(negedge push_clk);
    arst_n = 1'b1;
    check_value(32'(pop_empty), 32'd1, "pop_empty after reset");
    check_value(32'(pop_items), 32'd0, "pop_items after reset");
    wait_credits("after reset");
    check_value(32'(push_ready), 32'd1, "push_ready with initial credits");
    fd = $fopen("test/cdc_fifo_tests.txt", "r");
    if (fd == 0) begin
      $display("Error: could not open the test command file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        cmd = '0;
        status = $fscanf(fd, "%s", cmd);
        if (status != 1) begin
          break;
        end
        if (cmd == CmdComment) begin
          status = $fgets(line_buf, fd);
        end else if (cmd == CmdPush) begin
          status = $fscanf(fd, "%h", arg);
          push_word(cdc_fifo_pkg::data_t'(arg), (pop_mode == ModeHold) ? HoldLimit : PushLimit,
                    taken);
          // Under hold a refusal is expected once the FIFO is full
          if (!taken && pop_mode != ModeHold) begin
            $display("Timeout at %0t: push of %0h was never accepted", $time, arg);
            errors++;
          end
        end else if (cmd == CmdDrain) begin
          if (pop_mode == ModeHold) begin
            check_full_hold();
          end
          drain_fifo();
        end else if (cmd == CmdHold) begin
          pop_mode = ModeHold;
          hold_accepted = 0;
        end else if (cmd == CmdRand) begin
          status = $fscanf(fd, "%d", arg);
          pop_mode = ModeRandom;
          for (int i = 0; i < int'(arg); i++) begin
            random_bits(`CDC_FIFO_WIDTH, rnd);
            push_word(cdc_fifo_pkg::data_t'(rnd), PushLimit, taken);
            if (!taken) begin
              $display("Timeout at %0t: random push %0d was never accepted", $time, i);
              errors++;
            end
          end
        end else begin
          $display("Error: unknown command %0s in the test file", cmd);
          errors++;
        end
      end
      $fclose(fd);
    end
    check_value(32'(expected.size()), 32'd0, "scoreboard empty at end");
    $display("Summary: %0d pushed, %0d popped, %0d errors", accepted_cnt, popped_cnt, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* test/cdc_fifo_tests.txt */
# command [argument], one command per line
# push <hex word> | drain | hold | rand <decimal count>
push 3c
push a5
push 00
push ff
push 5a
push 81
drain
hold
push 11
push 12
push 13
push 14
push 15
push 16
push 17
push 18
push 19
drain
rand 200
drain
push 7e
push e7
drain
